// ==== list.f ====
hdl/cast_pkg.sv
hdl/fp_classifier.sv
hdl/cast_normalizer.sv
hdl/cast_shifter.sv
hdl/cast_rounding.sv
hdl/cast_result_select.sv
hdl/fp_int_cast.sv
testbench/cast_properties.sv
testbench/cast_checker.sv
testbench/tb_fp_int_cast.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_fp_int_cast
FILELIST  := list.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^NO ERRORS$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_fp_int_cast.sv ====
// Testbench for the binary32 <-> int32 converter
// Clock and reset, LCG driven stimulus for five tests, run timeout,
// checker and bound assertions

`timescale 1ns/100ps
`default_nettype none

module tb_fp_int_cast
  import cast_pkg::*;
;

  localparam int N_EXACT   = 40;
  localparam int N_I2F     = 100;
  localparam int N_F2I     = 100;
  localparam int N_SPECIAL = 36;
  localparam int N_SMALL   = 60;
  localparam int TOTAL     = N_EXACT + N_I2F + N_F2I + N_SPECIAL + N_SMALL;
  localparam int LIMIT     = TOTAL + 20;

  logic       clk;
  logic       rst_n;
  word_t      operand;
  operation_e op;
  logic       op_mod;
  roundmode_e rnd_mode;
  logic       vec_valid;
  logic       vec_last;
  int         test_id;
  word_t      result;
  status_t    status;
  int         check_count;
  int         error_count;
  int         test_count;
  int         cycle_count = 0;
  word_t      lcg_state = 32'd49;

  fp_int_cast fp_int_cast_i (
    .clk_i      ( clk      ),
    .rst_n_i    ( rst_n    ),
    .operand_i  ( operand  ),
    .op_i       ( op       ),
    .op_mod_i   ( op_mod   ),
    .rnd_mode_i ( rnd_mode ),
    .result_o   ( result   ),
    .status_o   ( status   )
  );

  cast_checker i_checker (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .operand_i     ( operand     ),
    .op_i          ( op          ),
    .op_mod_i      ( op_mod      ),
    .rnd_mode_i    ( rnd_mode    ),
    .valid_i       ( vec_valid   ),
    .last_i        ( vec_last    ),
    .test_id_i     ( test_id     ),
    .result_i      ( result      ),
    .status_i      ( status      ),
    .check_count_o ( check_count ),
    .error_count_o ( error_count ),
    .test_count_o  ( test_count  )
  );

  bind fp_int_cast cast_properties i_properties (
    .clk_i    ( clk_i    ),
    .rst_n_i  ( rst_n_i  ),
    .norm_i   ( norm_q   ),
    .status_i ( status_o )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count == LIMIT) begin
      $display("Timeout: only %0d of %0d results checked after %0d cycles",
               check_count, TOTAL, LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------
  task automatic apply_vector(input int id, input logic last, input word_t a,
                              input operation_e o, input logic uns, input int mode);
    @(posedge clk);
    operand   <= a;
    op        <= o;
    op_mod    <= uns;
    rnd_mode  <= roundmode_e'(mode);
    vec_valid <= 1'b1;
    vec_last  <= last;
    test_id   <= id;
  endtask

  task automatic exact_int_to_float();
    word_t r;
    word_t r2;
    word_t val;
    logic  uns;
    for (int i = 0; i < N_EXACT; i++) begin
      r   = lcg_next();
      r2  = lcg_next();
      uns = r[30];
      val = {8'd0, r2[31:8]} << r[27:25];  // 24 significant bits at most
      if (!uns && r[31]) val = -val;
      case (i)
        0: val = '0;
        1: begin
          val = 32'h8000_0000;
          uns = 1'b0;
        end
        2: begin
          val = 32'hffff_ffff;
          uns = 1'b0;
        end
        3: begin
          val = 32'hffff_ff00;
          uns = 1'b1;
        end
        default: ;
      endcase
      apply_vector(0, i == N_EXACT - 1, val, I2F, uns, i % 5);
    end
  endtask

  task automatic random_int_to_float();
    word_t r;
    for (int i = 0; i < N_I2F; i++) begin
      r = lcg_next();
      apply_vector(1, i == N_I2F - 1, lcg_next(), I2F, r[29], i % 5);
    end
  endtask

  task automatic in_range_float_to_int();
    word_t r;
    word_t r2;
    word_t a;
    logic  uns;
    int    ue;
    for (int i = 0; i < N_F2I; i++) begin
      r   = lcg_next();
      r2  = lcg_next();
      uns = r[29];
      ue  = int'(r[15:8]) % (uns ? 32 : 31);
      a   = {r[31] & ~uns, 8'(127 + ue), r2[22:0]};
      if (i == 0) begin  // -2^31, the only signed value at exponent 31
        a   = 32'hcf00_0000;
        uns = 1'b0;
      end
      apply_vector(2, i == N_F2I - 1, a, F2I, uns, i % 5);
    end
  endtask

  task automatic special_float_to_int();
    word_t r;
    word_t r2;
    word_t a;
    logic  uns;
    for (int i = 0; i < N_SPECIAL; i++) begin
      r   = lcg_next();
      r2  = lcg_next();
      uns = r[29];
      case (i % 6)
        0: a = {r[31], 9'h1ff, r2[21:0]};                    // Quiet NaN
        1: a = {r[31], 9'h1fe, r2[21:1], 1'b1};              // Signalling NaN
        2: a = 32'h7f80_0000;
        3: a = 32'hff80_0000;
        4: a = {r[31], 8'(159 + int'(r[15:8]) % 96), r2[22:0]};
        default: begin
          a   = {1'b1, 8'(127 + int'(r[15:8]) % 32), r2[22:0]};
          uns = 1'b1;
        end
      endcase
      // Signed range edges just below -2^31 and from +2^31 up
      if (i == N_SPECIAL - 2) begin
        a   = 32'hcf00_0001;
        uns = 1'b0;
      end
      if (i == N_SPECIAL - 1) begin
        a   = {1'b0, 8'd158, r2[22:0]};
        uns = 1'b0;
      end
      apply_vector(3, i == N_SPECIAL - 1, a, F2I, uns, i % 5);
    end
  endtask

  task automatic small_float_to_int();
    word_t r;
    word_t r2;
    word_t a;
    for (int i = 0; i < N_SMALL; i++) begin
      r  = lcg_next();
      r2 = lcg_next();
      case (i % 4)
        0: a = {r[31], 31'd0};
        1: a = {r[31], 8'd0, r2[22:1], 1'b1};
        2: a = {r[31], 8'd126, r2[22:0]};                   // 0.5 up to 1
        default: a = {r[31], 8'(1 + int'(r[15:8]) % 126), r2[22:0]};
      endcase
      apply_vector(4, i == N_SMALL - 1, a, F2I, r[29], i % 5);
    end
  endtask

  initial begin : main
    rst_n     = 1'b0;
    operand   = '0;
    op        = I2F;
    op_mod    = 1'b0;
    rnd_mode  = RNE;
    vec_valid = 1'b0;
    vec_last  = 1'b0;
    test_id   = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    exact_int_to_float();
    random_int_to_float();
    in_range_float_to_int();
    special_float_to_int();
    small_float_to_int();
    @(posedge clk);
    vec_valid <= 1'b0;
    vec_last  <= 1'b0;
    while (check_count < TOTAL) @(posedge clk);  // Drain the pipeline
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/cast_checker.sv ====
// Result checker for the binary32 <-> int32 converter
// Keeps a two-deep input history to line up with the pipeline latency,
// computes the expected result and flags, and reports per test

`timescale 1ns/100ps
`default_nettype none

module cast_checker
  import cast_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  word_t      operand_i,
  input  operation_e op_i,
  input  logic       op_mod_i,
  input  roundmode_e rnd_mode_i,
  input  logic       valid_i,
  input  logic       last_i,      // Final vector of a test
  input  int         test_id_i,
  input  word_t      result_i,
  input  status_t    status_i,
  output int         check_count_o,
  output int         error_count_o,
  output int         test_count_o
);

  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] test_id;
    word_t      operand;
    logic       is_f2i;
    logic       uns;
    logic [2:0] mode;
  } vector_t;

  vector_t hist0;
  vector_t hist1;
  int      test_checks;
  int      test_errors;

  function automatic string test_name(input logic [7:0] id);
    case (id)
      8'd0:    return "i2f_exact";
      8'd1:    return "i2f_rounding";
      8'd2:    return "f2i_in_range";
      8'd3:    return "f2i_saturation";
      8'd4:    return "f2i_small";
      default: return "unknown";
    endcase
  endfunction

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------
  function automatic logic round_up(input logic [2:0] mode, input logic sign,
                                    input logic lsb, input logic rbit, input logic sticky);
    case (mode)
      3'd0:    return rbit && (sticky || lsb);  // Ties to even
      3'd2:    return (rbit || sticky) && sign;
      3'd3:    return (rbit || sticky) && !sign;
      3'd4:    return rbit;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t saturate(input logic sign, input logic uns);
    if (uns) return sign ? 32'h0000_0000 : 32'hffff_ffff;
    return sign ? 32'h8000_0000 : 32'h7fff_ffff;
  endfunction

  function automatic logic [36:0] i2f_ref(input word_t a, input logic uns,
                                          input logic [2:0] mode);
    logic        sign;
    word_t       m32;
    logic [63:0] m;
    logic [63:0] q;
    int          p;
    int          sh;
    logic        rbit;
    logic        sticky;
    sign = !uns && a[31];
    m32  = sign ? -a : a;
    m    = {32'd0, m32};
    if (m == 0) return '0;
    p = 0;
    for (int i = 0; i < 32; i++) begin
      if (m[i]) p = i;
    end
    rbit   = 1'b0;
    sticky = 1'b0;
    if (p <= 23) begin
      q = m << (23 - p);
    end else begin
      sh     = p - 23;
      q      = m >> sh;
      rbit   = m[sh-1];
      sticky = (m & ((64'd1 << (sh - 1)) - 1)) != 0;
      q      = q + 64'(round_up(mode, sign, q[0], rbit, sticky));
      if (q[24]) begin  // Carry out of 24 bits
        q = q >> 1;
        p = p + 1;
      end
    end
    return {4'b0000, rbit | sticky, sign, 8'(p + 127), q[22:0]};
  endfunction

  function automatic logic [36:0] f2i_ref(input word_t a, input logic uns,
                                          input logic [2:0] mode);
    logic        sign;
    logic [7:0]  e;
    logic [63:0] mant;
    logic [63:0] mag;
    int          sh;
    logic        rbit;
    logic        sticky;
    sign = a[31];
    e    = a[30:23];
    if (e == 8'hff && a[22:0] != 0) return {5'b10000, uns ? 32'hffff_ffff : 32'h7fff_ffff};
    if (e >= 8'd159) return {5'b10000, saturate(sign, uns)};  // Also infinity
    mant   = {40'd0, e != 0, a[22:0]};
    sh     = 150 - ((e == 0) ? 1 : int'(e));
    rbit   = 1'b0;
    sticky = 1'b0;
    if (sh <= 0) begin
      mag = mant << (-sh);
    end else if (sh >= 64) begin
      mag    = '0;
      sticky = mant != 0;
    end else begin
      mag    = mant >> sh;
      rbit   = mant[sh-1];
      sticky = (mant & ((64'd1 << (sh - 1)) - 1)) != 0;
    end
    mag = mag + 64'(round_up(mode, sign, mag[0], rbit, sticky));
    if (uns && sign && mag != 0) return {5'b10000, 32'h0};
    if (uns && mag > 64'hffff_ffff) return {5'b10000, saturate(sign, uns)};
    if (!uns && !sign && mag > 64'h7fff_ffff) return {5'b10000, saturate(sign, uns)};
    if (!uns && sign && mag > 64'h8000_0000) return {5'b10000, saturate(sign, uns)};
    return {4'b0000, rbit | sticky, sign ? -mag[31:0] : mag[31:0]};
  endfunction

  function automatic logic [36:0] convert_ref(input word_t a, input logic is_f2i,
                                              input logic uns, input logic [2:0] mode);
    return is_f2i ? f2i_ref(a, uns, mode) : i2f_ref(a, uns, mode);
  endfunction

  // --------------------------------------------------------------------
  // Latency-aligned compare
  // --------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_n_i) begin : compare
    logic [36:0] expected;
    logic        bad;
    if (!rst_n_i) begin
      hist0         <= '0;
      hist1         <= '0;
      test_checks   <= 0;
      test_errors   <= 0;
      check_count_o <= 0;
      error_count_o <= 0;
      test_count_o  <= 0;
    end else begin
      hist0 <= '{valid: valid_i, last: last_i, test_id: 8'(test_id_i), operand: operand_i,
                 is_f2i: (op_i == F2I), uns: op_mod_i, mode: rnd_mode_i};
      hist1 <= hist0;
      if (hist1.valid) begin
        expected = convert_ref(hist1.operand, hist1.is_f2i, hist1.uns, hist1.mode);
        bad      = ({status_i, result_i} !== expected);
        if (bad) begin
          $display("ERROR %s: operand %h mode %0d, expected %h status %b, actual %h status %b",
                   test_name(hist1.test_id), hist1.operand, hist1.mode,
                   expected[31:0], expected[36:32], result_i, status_i);
        end
        if (hist1.last) begin
          $display("Test %s: %0d vectors, %0d errors", test_name(hist1.test_id),
                   test_checks + 1, test_errors + int'(bad));
          test_checks  <= 0;
          test_errors  <= 0;
          test_count_o <= test_count_o + 1;
        end else begin
          test_checks <= test_checks + 1;
          test_errors <= test_errors + int'(bad);
        end
        check_count_o <= check_count_o + 1;
        error_count_o <= error_count_o + int'(bad);
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/cast_properties.sv ====
// Concurrent checks on the binary32 <-> int32 converter
// Bound into the top level, watches the first stage record and the
// registered status flags

`timescale 1ns/100ps
`default_nettype none

module cast_properties
  import cast_pkg::*;
(
  input logic        clk_i,
  input logic        rst_n_i,
  input norm_stage_t norm_i,    // Operation one cycle before the output
  input status_t     status_i
);

  // No division anywhere in the datapath
  dz_never_set: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !status_i.DZ)
    else $error("Divide-by-zero flag raised by a conversion");

  f2i_no_of_uf: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (norm_i.op == F2I) |=> (!status_i.OF && !status_i.UF))
    else $error("Float to integer result raised overflow or underflow");

  // A 32-bit integer always fits the binary32 range
  i2f_no_nv: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (norm_i.op == I2F) |=> !status_i.NV)
    else $error("Integer to float result raised invalid");

  status_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(status_i))
    else $error("Status output is unknown");

endmodule

`default_nettype wire

// ==== hdl/fp_int_cast.sv ====
// Binary32 <-> 32-bit integer converter
// Two register stages, one conversion accepted per clock, fixed latency
// of two cycles, signed or unsigned integers, all RISC-V rounding modes

`timescale 1ns/100ps
`default_nettype none

module fp_int_cast
  import cast_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  word_t      operand_i,
  input  operation_e op_i,
  input  logic       op_mod_i,    // Unsigned integer when set
  input  roundmode_e rnd_mode_i,
  output word_t      result_o,
  output status_t    status_o
);

  norm_stage_t norm_q;
  word_t       pre_round_abs;
  round_bits_t round_bits;
  logic        of_before;
  logic        uf_before;
  word_t       rounded_abs;
  logic        rounded_sign;

  // Stage 1, registered
  cast_normalizer i_normalizer (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .operand_i  ( operand_i  ),
    .op_i       ( op_i       ),
    .op_mod_i   ( op_mod_i   ),
    .rnd_mode_i ( rnd_mode_i ),
    .norm_q_o   ( norm_q     )
  );

  // Stage 2
  cast_shifter i_shifter (
    .norm_i          ( norm_q        ),
    .pre_round_abs_o ( pre_round_abs ),
    .round_bits_o    ( round_bits    ),
    .of_before_o     ( of_before     ),
    .uf_before_o     ( uf_before     )
  );

  cast_rounding i_rounding (
    .abs_i         ( pre_round_abs   ),
    .sign_i        ( norm_q.sign     ),
    .round_bits_i  ( round_bits      ),
    .rnd_mode_i    ( norm_q.rnd_mode ),
    .abs_rounded_o ( rounded_abs     ),
    .sign_o        ( rounded_sign    )
  );

  cast_result_select i_result_select (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .norm_i         ( norm_q       ),
    .rounded_abs_i  ( rounded_abs  ),
    .rounded_sign_i ( rounded_sign ),
    .round_bits_i   ( round_bits   ),
    .of_before_i    ( of_before    ),
    .uf_before_i    ( uf_before    ),
    .result_o       ( result_o     ),
    .status_o       ( status_o     )
  );

endmodule

`default_nettype wire

// ==== hdl/cast_result_select.sv ====
// Result assembly and output stage
// Two's complement for integer results, overflow after rounding,
// saturation and zero results, exception flags, output register

`timescale 1ns/100ps
`default_nettype none

module cast_result_select
  import cast_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  norm_stage_t norm_i,
  input  word_t       rounded_abs_i,
  input  logic        rounded_sign_i,
  input  round_bits_t round_bits_i,
  input  logic        of_before_i,
  input  logic        uf_before_i,
  output word_t       result_o,
  output status_t     status_o
);

  logic    src_is_int;
  logic    dst_is_int;
  logic    fp_uf_after;
  logic    fp_of_after;
  logic    int_of_after;
  logic    of_after;
  word_t   fp_result;
  word_t   int_res;
  word_t   int_special;
  word_t   int_result;
  word_t   result_d;
  logic    int_res_zero;
  logic    int_is_special;
  status_t fp_status;
  status_t int_status;
  status_t status_d;

  assign src_is_int = (norm_i.op == I2F);
  assign dst_is_int = (norm_i.op == F2I);

  // --------------------------------------------------------------------
  // Float destination
  // --------------------------------------------------------------------
  assign fp_uf_after = (rounded_abs_i[MAN_BITS +: EXP_BITS] == '0);
  assign fp_of_after = (rounded_abs_i[MAN_BITS +: EXP_BITS] == '1);
  assign fp_result   = (src_is_int && norm_i.mant_is_zero) ? '0
                     : {rounded_sign_i, rounded_abs_i[EXP_BITS+MAN_BITS-1:0]};

  always_comb begin : fp_flags
    fp_status.NV = src_is_int & (of_before_i | of_after);
    fp_status.DZ = 1'b0;
    fp_status.OF = ~src_is_int & ~norm_i.info.is_inf & (of_before_i | of_after);
    fp_status.NX = (|round_bits_i) |
                   (~src_is_int & ~norm_i.info.is_inf & (of_before_i | of_after));
    fp_status.UF = (uf_before_i | fp_uf_after) & fp_status.NX;
  end

  // --------------------------------------------------------------------
  // Integer destination
  // --------------------------------------------------------------------
  assign int_res      = rounded_sign_i ? -rounded_abs_i : rounded_abs_i;
  assign int_res_zero = (int_res == '0);

  always_comb begin : int_overflow
    int_of_after = 1'b0;
    // Rounding can carry into the sign bit, or past it when unsigned
    if (!rounded_sign_i &&
        norm_i.input_exp == exp_t'(INT_WIDTH - 2) + exp_t'(norm_i.op_mod)) begin
      int_of_after = norm_i.op_mod ? ~int_res[INT_WIDTH-1] : ~int_res[INT_WIDTH-2];
    end
  end

  assign of_after = dst_is_int ? int_of_after : fp_of_after;

  // Positive max by default, negatives go to min or zero except for NaN
  always_comb begin : saturate
    int_special = {norm_i.op_mod, {(INT_WIDTH-1){1'b1}}};
    if (norm_i.sign && !norm_i.info.is_nan) begin
      int_special = ~int_special;
    end
  end

  assign int_is_special = norm_i.info.is_nan | norm_i.info.is_inf | of_before_i | of_after
                        | (norm_i.sign & norm_i.op_mod & ~int_res_zero);

  assign int_result = int_is_special ? int_special : int_res;
  assign int_status = int_is_special ? status_t'{NV: 1'b1, default: 1'b0}
                                     : status_t'{NX: |round_bits_i, default: 1'b0};

  assign result_d = dst_is_int ? int_result : fp_result;
  assign status_d = dst_is_int ? int_status : fp_status;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : out_reg
    if (!rst_n_i) begin
      result_o <= '0;
      status_o <= '0;
    end else begin
      result_o <= result_d;
      status_o <= status_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cast_rounding.sv ====
// Magnitude rounding by RISC-V rounding mode
// Adds one ulp to a sign-magnitude value depending on its round and
// sticky bits, the sign and the selected mode

`timescale 1ns/100ps
`default_nettype none

module cast_rounding
  import cast_pkg::*;
(
  input  word_t       abs_i,
  input  logic        sign_i,
  input  round_bits_t round_bits_i,
  input  roundmode_e  rnd_mode_i,
  output word_t       abs_rounded_o,
  output logic        sign_o
);

  logic round_up;

  always_comb begin : decide_round
    case (rnd_mode_i)
      RNE: begin
        case (round_bits_i)
          2'b10:   round_up = abs_i[0];  // Tie goes to the even value
          2'b11:   round_up = 1'b1;
          default: round_up = 1'b0;
        endcase
      end
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_bits_i) & sign_i;   // Away from zero if negative
      RUP:     round_up = (|round_bits_i) & ~sign_i;
      RMM:     round_up = round_bits_i[1];            // Ties away
      default: round_up = 1'b0;
    endcase
  end

  assign abs_rounded_o = abs_i + word_t'(round_up);
  assign sign_o        = sign_i;  // No subtraction, so sign never flips

endmodule

`default_nettype wire

// ==== hdl/cast_shifter.sv ====
// Destination alignment for the conversion pipeline
// Shifts the normalized mantissa to integer position or to a float
// fraction, denormalizes small results, flags over- and underflow ahead
// of rounding, and collapses the dropped bits into round and sticky

`timescale 1ns/100ps
`default_nettype none

module cast_shifter
  import cast_pkg::*;
(
  input  norm_stage_t norm_i,
  output word_t       pre_round_abs_o,
  output round_bits_t round_bits_o,
  output logic        of_before_o,
  output logic        uf_before_o
);

  logic                     src_is_int;
  logic                     dst_is_int;
  logic [EXP_BITS-1:0]      final_exp;
  logic [2*INT_MAN_WIDTH:0] preshift_mant;
  logic [2*INT_MAN_WIDTH:0] dest_mant;
  shamt_t                   denorm_shamt;
  logic [MAN_BITS-1:0]      final_mant;
  word_t                    final_int;
  round_bits_t              fp_round_bits;
  round_bits_t              int_round_bits;

  assign src_is_int = (norm_i.op == I2F);
  assign dst_is_int = (norm_i.op == F2I);

  always_comb begin : cast_value
    final_exp     = norm_i.dest_exp[EXP_BITS-1:0];
    preshift_mant = {norm_i.mant, {(INT_MAN_WIDTH+1){1'b0}}};  // Leftmost in the shifter
    denorm_shamt  = '0;
    of_before_o   = 1'b0;
    uf_before_o   = 1'b0;

    if (dst_is_int) begin
      // Unsigned range is one bit wider, -2^31 is still representable
      if ((norm_i.input_exp >= exp_t'(INT_WIDTH - 1) + exp_t'(norm_i.op_mod)) &&
          !(!norm_i.op_mod && norm_i.sign &&
            (norm_i.input_exp == exp_t'(INT_WIDTH - 1)) &&
            (norm_i.mant == {1'b1, {(INT_MAN_WIDTH-1){1'b0}}}))) begin
        of_before_o = 1'b1;
      end else if (norm_i.input_exp < -exp_t'(1)) begin
        denorm_shamt = shamt_t'(INT_WIDTH + 1);  // Everything into sticky
        uf_before_o  = 1'b1;
      end else begin
        denorm_shamt = shamt_t'(exp_t'(INT_WIDTH - 1) - norm_i.input_exp);
      end
    end else begin
      if ((norm_i.dest_exp >= exp_t'(2**EXP_BITS - 1)) ||
          (!src_is_int && norm_i.info.is_inf)) begin
        final_exp     = EXP_BITS'(2**EXP_BITS - 2);  // Largest normal
        preshift_mant = '1;                          // with R and S set
        of_before_o   = 1'b1;
      end else if (norm_i.dest_exp < exp_t'(1) &&
                   norm_i.dest_exp >= -exp_t'(MAN_BITS)) begin
        final_exp    = '0;
        denorm_shamt = shamt_t'(exp_t'(1) - norm_i.dest_exp);
        uf_before_o  = 1'b1;
      end else if (norm_i.dest_exp < -exp_t'(MAN_BITS)) begin
        // Shift limited so the sticky bit survives
        final_exp    = '0;
        denorm_shamt = shamt_t'(MAN_BITS + 2);
        uf_before_o  = 1'b1;
      end
    end
  end

  assign dest_mant = preshift_mant >> denorm_shamt;

  // Hidden bit sits at the top and is dropped for floats
  assign {final_mant, fp_round_bits[1]} = dest_mant[2*INT_MAN_WIDTH-1 -: MAN_BITS+1];
  assign {final_int, int_round_bits[1]} = dest_mant[2*INT_MAN_WIDTH -: INT_WIDTH+1];
  assign fp_round_bits[0]  = |dest_mant[2*INT_MAN_WIDTH-MAN_BITS-2:0];
  assign int_round_bits[0] = |dest_mant[2*INT_MAN_WIDTH-INT_WIDTH-1:0];

  assign pre_round_abs_o = dst_is_int ? final_int : {1'b0, final_exp, final_mant};
  assign round_bits_o    = dst_is_int ? int_round_bits : fp_round_bits;

endmodule

`default_nettype wire

// ==== hdl/cast_normalizer.sv ====
// Conversion front end and first pipeline stage
// Extracts sign and magnitude from an integer or a float operand,
// renormalizes the mantissa by a leading-zero count, unbiases and
// rebiases the exponent, and registers the resulting record

`timescale 1ns/100ps
`default_nettype none

module cast_normalizer
  import cast_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  word_t       operand_i,
  input  operation_e  op_i,
  input  logic        op_mod_i,
  input  roundmode_e  rnd_mode_i,
  output norm_stage_t norm_q_o
);

  fp_info_t             info;
  logic                 src_is_int;
  logic                 int_sign;
  mant_t                int_mant;
  mant_t                fp_mant;
  mant_t                encoded_mant;
  logic [LZC_WIDTH-1:0] renorm_shamt;
  logic                 mant_is_zero;
  exp_t                 fp_input_exp;
  exp_t                 int_input_exp;
  exp_t                 input_exp;
  norm_stage_t          norm_d;

  fp_classifier i_classifier (
    .operand_i ( operand_i ),
    .info_o    ( info      )
  );

  // --------------------------------------------------------------------
  // Input mantissa
  // --------------------------------------------------------------------
  assign src_is_int = (op_i == I2F);
  assign int_sign   = operand_i[INT_WIDTH-1] & ~op_mod_i;  // Only signed ints go negative
  assign int_mant   = int_sign ? -operand_i : operand_i;

  // Hidden bit only for normals, padded with zeros above
  assign fp_mant = {{(INT_MAN_WIDTH-MAN_BITS-1){1'b0}}, info.is_normal,
                    operand_i[MAN_BITS-1:0]};

  assign encoded_mant = src_is_int ? int_mant : fp_mant;
  assign mant_is_zero = (encoded_mant == '0);

  // Highest set bit wins, zero input counts as zero
  always_comb begin : lead_zero_count
    renorm_shamt = '0;
    for (int i = 0; i < INT_MAN_WIDTH; i++) begin
      if (encoded_mant[i]) begin
        renorm_shamt = LZC_WIDTH'(INT_MAN_WIDTH - 1 - i);
      end
    end
  end

  // --------------------------------------------------------------------
  // Exponents
  // --------------------------------------------------------------------
  // Subnormals use exponent 1, offset undoes the zero padding
  assign fp_input_exp = exp_t'({1'b0, operand_i[MAN_BITS +: EXP_BITS]})
                      + exp_t'(info.is_subnormal) - exp_t'(BIAS)
                      - exp_t'(renorm_shamt) + exp_t'(INT_MAN_WIDTH - 1 - MAN_BITS);
  assign int_input_exp = exp_t'(INT_MAN_WIDTH - 1) - exp_t'(renorm_shamt);
  assign input_exp     = src_is_int ? int_input_exp : fp_input_exp;

  always_comb begin : build_record
    norm_d.sign         = src_is_int ? int_sign : operand_i[INT_WIDTH-1];
    norm_d.input_exp    = input_exp;
    norm_d.dest_exp     = input_exp + exp_t'(BIAS);
    norm_d.mant         = encoded_mant << renorm_shamt;
    norm_d.mant_is_zero = mant_is_zero;
    norm_d.info         = info;
    norm_d.op           = op_i;
    norm_d.op_mod       = op_mod_i;
    norm_d.rnd_mode     = rnd_mode_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : stage_reg
    if (!rst_n_i) begin
      norm_q_o <= '0;
    end else begin
      norm_q_o <= norm_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fp_classifier.sv ====
// Binary32 operand classifier
// Decodes exponent and fraction fields into zero, subnormal, normal,
// infinity and quiet or signalling NaN flags

`timescale 1ns/100ps
`default_nettype none

module fp_classifier
  import cast_pkg::*;
(
  input  word_t    operand_i,
  output fp_info_t info_o
);

  logic [EXP_BITS-1:0] exp_field;
  logic [MAN_BITS-1:0] man_field;
  logic                exp_all_ones;
  logic                exp_all_zero;
  logic                man_zero;

  assign exp_field    = operand_i[MAN_BITS +: EXP_BITS];
  assign man_field    = operand_i[MAN_BITS-1:0];
  assign exp_all_ones = &exp_field;
  assign exp_all_zero = ~|exp_field;
  assign man_zero     = ~|man_field;

  always_comb begin : classify
    info_o.is_normal     = ~exp_all_zero & ~exp_all_ones;
    info_o.is_zero       = exp_all_zero & man_zero;
    info_o.is_subnormal  = exp_all_zero & ~man_zero;
    info_o.is_inf        = exp_all_ones & man_zero;
    info_o.is_nan        = exp_all_ones & ~man_zero;
    // Top fraction bit is the quiet bit
    info_o.is_signalling = info_o.is_nan & ~man_field[MAN_BITS-1];
    info_o.is_quiet      = info_o.is_nan & man_field[MAN_BITS-1];
  end

endmodule

`default_nettype wire

// ==== hdl/cast_pkg.sv ====
// Shared definitions for the binary32 <-> int32 conversion pipeline
// Format constants, vector types, operation and rounding encodings,
// and the records passed between the pipeline stages

`default_nettype none

package cast_pkg;

  // --------------------------------------------------------------------
  // Format constants
  // --------------------------------------------------------------------
  localparam int unsigned EXP_BITS  = 8;
  localparam int unsigned MAN_BITS  = 23;
  localparam int unsigned BIAS      = 127;
  localparam int unsigned INT_WIDTH = 32;

  // Internal mantissa holds the hidden bit plus fraction, or a whole integer
  localparam int unsigned INT_MAN_WIDTH = 32;
  // Signed, wide enough for the smallest subnormal exponent
  localparam int unsigned INT_EXP_WIDTH = 10;
  localparam int unsigned LZC_WIDTH     = 5;

  // --------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------
  typedef logic [INT_WIDTH-1:0]            word_t;
  typedef logic [INT_MAN_WIDTH-1:0]        mant_t;
  typedef logic signed [INT_EXP_WIDTH-1:0] exp_t;
  typedef logic [LZC_WIDTH:0]              shamt_t;  // Reaches INT_WIDTH+1
  typedef logic [1:0]                      round_bits_t;  // {round, sticky}

  typedef enum logic {
    I2F = 1'b0,
    F2I = 1'b1
  } operation_e;

  // RISC-V rm field encodings
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // --------------------------------------------------------------------
  // Records
  // --------------------------------------------------------------------
  typedef struct packed {
    logic NV;  // Invalid
    logic DZ;  // Divide by zero
    logic OF;
    logic UF;
    logic NX;  // Inexact
  } status_t;

  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // Contents of the first pipeline register
  typedef struct packed {
    logic       sign;
    exp_t       input_exp;  // Unbiased
    exp_t       dest_exp;   // Rebiased for a float result
    mant_t      mant;       // Leading one at the top
    logic       mant_is_zero;
    fp_info_t   info;
    operation_e op;
    logic       op_mod;     // Unsigned integer when set
    roundmode_e rnd_mode;
  } norm_stage_t;

endpackage

`default_nettype wire
